// ==== hw/noc_router_pkg.sv ====
`default_nettype none

package noc_router_pkg;

  // ##########################################################################
  // Flit format
  // ##########################################################################

  typedef logic [2:0]  coord_t;
  typedef logic [15:0] payload_t;

  typedef struct packed {
    coord_t x;
    coord_t y;
  } location_t;

  typedef enum logic [1:0] {
    HEAD   = 2'd0,
    BODY   = 2'd1,
    TAIL   = 2'd2,
    SINGLE = 2'd3 // A one-flit packet is both head and tail.
  } flit_kind_t;

  typedef struct packed {
    flit_kind_t kind;
    location_t  dest;    // Only meaningful in HEAD and SINGLE flits.
    payload_t   payload;
  } flit_t;

  // ##########################################################################
  // Ports
  // ##########################################################################

  localparam int NUM_PORTS = 5;

  typedef enum logic [2:0] {
    PORT_X_PLUS  = 3'd0,
    PORT_X_MINUS = 3'd1,
    PORT_Y_PLUS  = 3'd2,
    PORT_Y_MINUS = 3'd3,
    PORT_LOCAL   = 3'd4
  } port_id_t;

  typedef logic [NUM_PORTS-1:0] port_mask_t;

  function automatic logic is_head(flit_t flit);
    return (flit.kind == HEAD) || (flit.kind == SINGLE);
  endfunction

  function automatic logic is_tail(flit_t flit);
    return (flit.kind == TAIL) || (flit.kind == SINGLE);
  endfunction

  // Dimension-order routing. X is resolved fully before Y.
  function automatic port_id_t xy_route(location_t dest, coord_t here_x, coord_t here_y);
    if (dest.x > here_x) return PORT_X_PLUS;
    if (dest.x < here_x) return PORT_X_MINUS;
    if (dest.y > here_y) return PORT_Y_PLUS;
    if (dest.y < here_y) return PORT_Y_MINUS;
    return PORT_LOCAL;
  endfunction

  function automatic port_mask_t port_mask(port_id_t port);
    return port_mask_t'(1) << port;
  endfunction

  function automatic port_id_t next_port(port_id_t port);
    return (port == PORT_LOCAL) ? PORT_X_PLUS : port_id_t'(port + 3'd1);
  endfunction

endpackage

`default_nettype wire

// ==== hw/noc_input_port.sv ====
`default_nettype none

module noc_input_port
  import noc_router_pkg::*;
#(
  parameter int BUFFER_DEPTH = 4
)(
  input  logic  clk,
  input  logic  rst_n,
  input  logic  flit_valid_i,
  input  flit_t flit_i,
  input  logic  pop_i,
  output logic  head_valid_o,
  output flit_t head_flit_o,
  output logic  credit_o
);

  localparam int PTR_W = (BUFFER_DEPTH > 1) ? $clog2(BUFFER_DEPTH) : 1;
  localparam int CNT_W = $clog2(BUFFER_DEPTH + 1);

  flit_t              mem [BUFFER_DEPTH];
  logic [PTR_W-1:0]   wr_ptr;
  logic [PTR_W-1:0]   rd_ptr;
  logic [CNT_W-1:0]   count;
  logic               push;
  logic               pop;
  logic               credit_q;

  // The upstream credit count guarantees a free slot for every valid flit.
  assign push = flit_valid_i;
  assign pop  = pop_i && head_valid_o;

  assign head_valid_o = (count != '0);
  assign head_flit_o  = mem[rd_ptr];
  assign credit_o     = credit_q;

  // ##########################################################################
  // Storage
  // ##########################################################################

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= flit_i;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_W'(BUFFER_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(BUFFER_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      count <= '0;
    end else begin
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count; // Idle, or push and pop cancel out.
      endcase
    end
  end

  // ##########################################################################
  // Credit return
  // ##########################################################################

  // One pulse per freed slot, in the cycle after the pop.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      credit_q <= 1'b0;
    end else begin
      credit_q <= pop;
    end
  end

endmodule

`default_nettype wire

// ==== hw/noc_route_selector.sv ====
`default_nettype none

module noc_route_selector
  import noc_router_pkg::*;
#(
  parameter coord_t ROUTER_X = '0,
  parameter coord_t ROUTER_Y = '0
)(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       head_valid_i,
  input  flit_t      head_flit_i,
  input  logic       pop_i,
  output port_mask_t request_o,
  output logic       last_o
);

  port_id_t   fresh_port;
  port_mask_t fresh_route;
  port_mask_t route;
  port_mask_t held_route_q;
  logic       busy_q;
  logic       popped;

  assign fresh_port  = xy_route(head_flit_i.dest, ROUTER_X, ROUTER_Y);
  assign fresh_route = port_mask(fresh_port);

  // Body and tail flits carry no destination, so they follow the held route.
  assign route = busy_q ? held_route_q : fresh_route;

  assign request_o = head_valid_i ? route : '0;
  assign last_o    = head_valid_i && is_tail(head_flit_i);

  assign popped = pop_i && head_valid_i;

  // ##########################################################################
  // Held route
  // ##########################################################################

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy_q       <= 1'b0;
      held_route_q <= '0;
    end else if (popped) begin
      if (is_tail(head_flit_i)) begin
        // Also covers a SINGLE flit, which never locks the route.
        busy_q       <= 1'b0;
        held_route_q <= '0;
      end else if (!busy_q && is_head(head_flit_i)) begin
        busy_q       <= 1'b1;
        held_route_q <= fresh_route;
      end
    end
  end

endmodule

`default_nettype wire

// ==== hw/noc_output_arbiter.sv ====
`default_nettype none

module noc_output_arbiter
  import noc_router_pkg::*;
#(
  parameter int BUFFER_DEPTH = 4
)(
  input  logic       clk,
  input  logic       rst_n,
  input  port_mask_t request_i,
  input  port_mask_t last_i,
  input  flit_t      flit_i [NUM_PORTS],
  output port_mask_t grant_o,
  output logic       flit_valid_o,
  output flit_t      flit_o,
  input  logic       credit_i
);

  localparam int CRED_W = $clog2(BUFFER_DEPTH + 1);

  logic [CRED_W-1:0] credits_q;
  logic              has_credit;
  logic              locked_q;
  port_id_t          owner_q;
  port_id_t          prio_q;
  port_id_t          winner;
  logic              found;
  logic              grant;
  logic              flit_valid_q;
  flit_t             flit_q;

  // ##########################################################################
  // Arbitration
  // ##########################################################################

  // A locked packet keeps the output until its last flit is granted.
  always_comb begin
    port_id_t candidate;
    candidate = prio_q;
    winner    = owner_q;
    found     = 1'b0;
    if (locked_q) begin
      found = request_i[owner_q];
    end else begin
      for (int i = 0; i < NUM_PORTS; i++) begin
        if (!found && request_i[candidate]) begin
          winner = candidate;
          found  = 1'b1;
        end
        candidate = next_port(candidate);
      end
    end
  end

  assign has_credit = (credits_q != '0);
  assign grant      = found && has_credit;
  assign grant_o    = grant ? port_mask(winner) : '0;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      locked_q <= 1'b0;
      owner_q  <= PORT_X_PLUS;
      prio_q   <= PORT_X_PLUS;
    end else if (grant) begin
      if (last_i[winner]) begin
        locked_q <= 1'b0;
        prio_q   <= next_port(winner); // Winner drops to lowest priority.
      end else begin
        locked_q <= 1'b1;
        owner_q  <= winner;
      end
    end
  end

  // ##########################################################################
  // Downstream credits
  // ##########################################################################

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      credits_q <= CRED_W'(BUFFER_DEPTH);
    end else begin
      case ({grant, credit_i})
        2'b10:   credits_q <= credits_q - 1'b1;
        2'b01:   credits_q <= credits_q + 1'b1;
        default: credits_q <= credits_q;
      endcase
    end
  end

  // ##########################################################################
  // Output stage
  // ##########################################################################

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      flit_valid_q <= 1'b0;
    end else begin
      flit_valid_q <= grant;
    end
  end

  always_ff @(posedge clk) begin
    if (grant) begin
      flit_q <= flit_i[winner];
    end
  end

  assign flit_valid_o = flit_valid_q;
  assign flit_o       = flit_q;

endmodule

`default_nettype wire

// ==== hw/noc_router.sv ====
`default_nettype none

module noc_router
  import noc_router_pkg::*;
#(
  parameter coord_t ROUTER_X     = '0,
  parameter coord_t ROUTER_Y     = '0,
  parameter int     BUFFER_DEPTH = 4
)(
  input  logic       clk,
  input  logic       rst_n,
  input  port_mask_t in_valid_i,
  input  flit_t      in_flit_i [NUM_PORTS],
  output port_mask_t in_credit_o,
  output port_mask_t out_valid_o,
  output flit_t      out_flit_o [NUM_PORTS],
  input  port_mask_t out_credit_i
);

  port_mask_t head_valid;
  flit_t      head_flit [NUM_PORTS];
  port_mask_t pop;
  port_mask_t last;
  port_mask_t request [NUM_PORTS];    // Indexed by input, one bit per output.
  port_mask_t req_by_out [NUM_PORTS]; // Indexed by output, one bit per input.
  port_mask_t grant [NUM_PORTS];      // Indexed by output, one bit per input.
  port_mask_t grant_by_in [NUM_PORTS];

  // ##########################################################################
  // Input side
  // ##########################################################################

  for (genvar g_in = 0; g_in < NUM_PORTS; g_in++) begin : g_input
    noc_input_port #(
      .BUFFER_DEPTH (BUFFER_DEPTH)
    ) u_input_port (
      .clk          (clk),
      .rst_n        (rst_n),
      .flit_valid_i (in_valid_i[g_in]),
      .flit_i       (in_flit_i[g_in]),
      .pop_i        (pop[g_in]),
      .head_valid_o (head_valid[g_in]),
      .head_flit_o  (head_flit[g_in]),
      .credit_o     (in_credit_o[g_in])
    );

    noc_route_selector #(
      .ROUTER_X (ROUTER_X),
      .ROUTER_Y (ROUTER_Y)
    ) u_route_selector (
      .clk          (clk),
      .rst_n        (rst_n),
      .head_valid_i (head_valid[g_in]),
      .head_flit_i  (head_flit[g_in]),
      .pop_i        (pop[g_in]),
      .request_o    (request[g_in]),
      .last_o       (last[g_in])
    );

    // An input requests one output at a time, so at most one grant bit is set.
    assign pop[g_in] = |grant_by_in[g_in];
  end

  // ##########################################################################
  // Crossbar
  // ##########################################################################

  for (genvar g_o = 0; g_o < NUM_PORTS; g_o++) begin : g_transpose_o
    for (genvar g_i = 0; g_i < NUM_PORTS; g_i++) begin : g_transpose_i
      assign req_by_out[g_o][g_i]  = request[g_i][g_o];
      assign grant_by_in[g_i][g_o] = grant[g_o][g_i];
    end
  end

  // ##########################################################################
  // Output side
  // ##########################################################################

  for (genvar g_out = 0; g_out < NUM_PORTS; g_out++) begin : g_output
    noc_output_arbiter #(
      .BUFFER_DEPTH (BUFFER_DEPTH)
    ) u_output_arbiter (
      .clk          (clk),
      .rst_n        (rst_n),
      .request_i    (req_by_out[g_out]),
      .last_i       (last),
      .flit_i       (head_flit),
      .grant_o      (grant[g_out]),
      .flit_valid_o (out_valid_o[g_out]),
      .flit_o       (out_flit_o[g_out]),
      .credit_i     (out_credit_i[g_out])
    );
  end

endmodule

`default_nettype wire

// ==== testbench/noc_router_model.svh ====
`ifndef NOC_ROUTER_MODEL_SVH
`define NOC_ROUTER_MODEL_SVH

  // ##########################################################################
  // Reference model
  // ##########################################################################

  flit_t send_q [NUM_PORTS][$];            // Flits still to be sent, per input.
  flit_t exp_q [NUM_PORTS * NUM_PORTS][$]; // Indexed by output * NUM_PORTS + input.
  int    gen_flits = 0;

  // Dimension-order rule. X is settled before Y is looked at.
  function automatic int expected_port(location_t dest);
    if (dest.x > ROUTER_X) return int'(PORT_X_PLUS);
    if (dest.x < ROUTER_X) return int'(PORT_X_MINUS);
    if (dest.y > ROUTER_Y) return int'(PORT_Y_PLUS);
    if (dest.y < ROUTER_Y) return int'(PORT_Y_MINUS);
    return int'(PORT_LOCAL);
  endfunction

  task automatic make_packet(int src, logic contention);
    int        len;
    int        out;
    location_t dest;
    flit_t     f;
    len = int'(random_bits(2)) + 1;
    if (contention) begin
      dest.x = ROUTER_X; // Every input aims at the local port.
      dest.y = ROUTER_Y;
    end else begin
      dest.x = coord_t'(random_bits(3));
      dest.y = coord_t'(random_bits(3));
    end
    out = expected_port(dest);
    for (int k = 0; k < len; k++) begin
      if (len == 1) f.kind = SINGLE;
      else if (k == 0) f.kind = HEAD;
      else if (k == len - 1) f.kind = TAIL;
      else f.kind = BODY;
      f.dest    = dest;
      f.payload = {src[2:0], 13'(random_bits(13))}; // Top bits tag the source input.
      send_q[src].push_back(f);
      exp_q[out * NUM_PORTS + src].push_back(f);
      gen_flits++;
    end
  endtask

  function automatic logic queues_empty();
    for (int q = 0; q < NUM_PORTS * NUM_PORTS; q++) begin
      if (exp_q[q].size() != 0) return 1'b0;
    end
    for (int p = 0; p < NUM_PORTS; p++) begin
      if (send_q[p].size() != 0) return 1'b0;
    end
    return 1'b1;
  endfunction

`endif

// ==== testbench/noc_router_tb.sv ====
`default_nettype none

module noc_router_tb
  import noc_router_pkg::*;
();

  localparam coord_t ROUTER_X     = 3'd3;
  localparam coord_t ROUTER_Y     = 3'd3;
  localparam int     BUFFER_DEPTH = 4;

  logic        clk = 1'b0;
  logic        rst_n = 1'b0;
  port_mask_t  in_valid = '0;
  flit_t       in_flit [NUM_PORTS] = '{default: '0};
  port_mask_t  in_credit;
  port_mask_t  out_valid;
  flit_t       out_flit [NUM_PORTS];
  port_mask_t  out_credit = '0;

  logic [15:0] lfsr_q = 16'd19801;
  int          phase = 0;        // 1 is random traffic, 2 is contention.
  int          loaded_phase = 0;
  int          cycle = 0;
  logic        idle = 1'b0;

  int   up_credits [NUM_PORTS] = '{default: BUFFER_DEPTH};
  int   sent       [NUM_PORTS] = '{default: 0};
  int   returned   [NUM_PORTS] = '{default: 0};
  int   gap        [NUM_PORTS] = '{default: 0};
  int   pkts_left  [NUM_PORTS] = '{default: 0};
  int   held       [NUM_PORTS] = '{default: 0}; // Received flits that still owe a credit.
  int   delay      [NUM_PORTS] = '{default: 0};
  logic in_packet  [NUM_PORTS] = '{default: 1'b0};
  int   packet_src [NUM_PORTS] = '{default: 0};

  noc_router #(
    .ROUTER_X     (ROUTER_X),
    .ROUTER_Y     (ROUTER_Y),
    .BUFFER_DEPTH (BUFFER_DEPTH)
  ) noc_router_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .in_valid_i   (in_valid),
    .in_flit_i    (in_flit),
    .in_credit_o  (in_credit),
    .out_valid_o  (out_valid),
    .out_flit_o   (out_flit),
    .out_credit_i (out_credit)
  );

  initial begin
    forever #5 clk = ~clk;
  end

  function automatic logic [15:0] lfsr_next(logic [15:0] state);
    return state[0] ? ((state >> 1) ^ 16'hB400) : (state >> 1);
  endfunction

  // One LFSR step per bit taken.
  function automatic int unsigned random_bits(int n);
    int unsigned value;
    value = 0;
    for (int k = 0; k < n; k++) begin
      value  = (value << 1) | {31'd0, lfsr_q[0]};
      lfsr_q = lfsr_next(lfsr_q);
    end
    return value;
  endfunction

  task automatic compare_values(string test_name, logic [31:0] expected, logic [31:0] actual);
    if (expected !== actual) begin
      $display("FAIL %s expected %0h actual %0h", test_name, expected, actual);
      $display("Errors found");
      $fatal(1);
    end
  endtask

  task automatic report_failure(string what);
    $display("%s", what);
    $display("Errors found");
    $fatal(1);
  endtask

  `include "noc_router_model.svh"

  task automatic check_output(int o, flit_t f);
    int    idx;
    flit_t expected;
    if (!in_packet[o]) begin
      if (f.kind != HEAD && f.kind != SINGLE)
        report_failure($sformatf("Output %0d started a packet with a %s flit.", o, f.kind.name()));
      packet_src[o] = int'(f.payload[15:13]);
      if (packet_src[o] >= NUM_PORTS)
        report_failure($sformatf("Output %0d carried a flit with no valid source tag.", o));
    end
    idx = o * NUM_PORTS + packet_src[o];
    if (exp_q[idx].size() == 0)
      report_failure($sformatf("Output %0d got a flit from input %0d that was not routed there.",
                               o, packet_src[o]));
    expected = exp_q[idx].pop_front();
    compare_values($sformatf("output %0d flit", o), {8'd0, expected}, {8'd0, f});
    in_packet[o] = !(f.kind == TAIL || f.kind == SINGLE);
  endtask

  // ##########################################################################
  // Upstream and downstream agents
  // ##########################################################################

  always @(posedge clk) begin
    flit_t f;
    if (rst_n) begin
      cycle = cycle + 1;
      if (cycle > 40 * gen_flits + 200)
        report_failure($sformatf("Timeout after %0d cycles with packets undelivered.", cycle));
      if (phase != loaded_phase) begin
        for (int i = 0; i < NUM_PORTS; i++) pkts_left[i] = (phase == 2) ? 8 : 12;
        loaded_phase = phase;
      end
      for (int i = 0; i < NUM_PORTS; i++) begin
        if (in_credit[i]) begin
          up_credits[i]++;
          returned[i]++;
          if (up_credits[i] > BUFFER_DEPTH)
            report_failure($sformatf("Input %0d returned more credits than it took flits.", i));
        end
        in_valid[i] <= 1'b0;
        if (gap[i] > 0) begin
          gap[i]--;
        end else begin
          if (send_q[i].size() == 0 && pkts_left[i] > 0) begin
            make_packet(i, phase == 2);
            pkts_left[i]--;
          end
          if (send_q[i].size() != 0 && up_credits[i] > 0) begin
            f = send_q[i].pop_front();
            in_valid[i] <= 1'b1;
            in_flit[i]  <= f;
            up_credits[i]--;
            sent[i]++;
            if (f.kind == TAIL || f.kind == SINGLE) gap[i] = int'(random_bits(2));
          end
        end
      end
      for (int o = 0; o < NUM_PORTS; o++) begin
        out_credit[o] <= 1'b0;
        if (out_valid[o]) begin
          held[o]++;
          if (held[o] > BUFFER_DEPTH)
            report_failure($sformatf("Output %0d overflowed the downstream buffer.", o));
          check_output(o, out_flit[o]);
        end
        if (delay[o] > 0) begin
          delay[o]--;
        end else if (held[o] > 0) begin
          out_credit[o] <= 1'b1;
          held[o]--;
          delay[o] = int'(random_bits(2));
        end
      end
      idle = queues_empty();
      for (int p = 0; p < NUM_PORTS; p++) begin
        if (pkts_left[p] != 0 || held[p] != 0 || in_packet[p]) idle = 1'b0;
      end
    end
  end

  // ##########################################################################
  // Test sequence
  // ##########################################################################

  task automatic check_outputs_low(string when);
    compare_values({when, " out_valid"}, 32'd0, {27'd0, out_valid});
    compare_values({when, " in_credit"}, 32'd0, {27'd0, in_credit});
  endtask

  // The upstream counter is BUFFER_DEPTH - sent + returned, so this also
  // brings every counter back to BUFFER_DEPTH.
  task automatic run_phase(int which);
    phase = which;
    do @(negedge clk); while (!idle);
    for (int i = 0; i < NUM_PORTS; i++) begin
      compare_values($sformatf("input %0d credits returned", i), sent[i], returned[i]);
    end
  endtask

  initial begin
    repeat (2) begin
      @(negedge clk);
      check_outputs_low("reset");
    end
    @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_outputs_low("first cycle after reset");
    run_phase(1);
    run_phase(2);
    $display("No errors");
    $finish;
  end

endmodule

`default_nettype wire

// ==== noc_router.f ====
+incdir+testbench
hw/noc_router_pkg.sv
hw/noc_input_port.sv
hw/noc_route_selector.sv
hw/noc_output_arbiter.sv
hw/noc_router.sv
testbench/noc_router_tb.sv

// ==== Makefile ====
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing -j 0 --top-module noc_router_tb -Mdir obj_dir -f noc_router.f
	./obj_dir/Vnoc_router_tb

clean:
	rm -rf obj_dir
